// ==== husky_pkg.sv ====
package husky_pkg;

   localparam int ADDR_WIDTH     = 8;
   localparam int DATA_WIDTH     = 8;
   localparam int USERIO_WIDTH   = 8;
   localparam int FIFO_DEPTH     = 16;
   localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH) + 1;  // extra bit tells full from empty
   localparam int FLASH_BIT      = 5;   // toggles every 32 clocks, 64 clock period

   // control register map
   localparam logic [ADDR_WIDTH-1:0] ADDR_TARGET_CTRL   = 8'h10;
   localparam logic [ADDR_WIDTH-1:0] ADDR_PIN_OE        = 8'h11;
   localparam logic [ADDR_WIDTH-1:0] ADDR_PIN_VAL       = 8'h12;
   localparam logic [ADDR_WIDTH-1:0] ADDR_USERIO_DRIVEN = 8'h13;
   localparam logic [ADDR_WIDTH-1:0] ADDR_USERIO_DATA   = 8'h14;

   // capture fifo
   localparam logic [ADDR_WIDTH-1:0] ADDR_FIFO_STATUS   = 8'h20;
   localparam logic [ADDR_WIDTH-1:0] ADDR_FIFO_DATA     = 8'h21;  // read pops one byte

   // bits of ADDR_TARGET_CTRL
   localparam int TC_POWER     = 0;
   localparam int TC_AVRPROG   = 1;
   localparam int TC_DEBUG     = 2;
   localparam int TC_DEBUG_SWD = 3;

   // bits of ADDR_PIN_OE and ADDR_PIN_VAL
   localparam int PIN_NRST = 0;
   localparam int PIN_PDID = 1;
   localparam int PIN_PDIC = 2;

   // fifo status byte
   localparam int ST_EMPTY   = 0;
   localparam int ST_FULL    = 1;
   localparam int ST_BLOCKED = 2;
   localparam int ST_ERROR   = 3;  // write 1 to clear error and block

endpackage

// ==== reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if import husky_pkg::*; ();

   logic [ADDR_WIDTH-1:0] address;
   logic [DATA_WIDTH-1:0] write_data;
   logic                  write;       // one-cycle pulse
   logic                  read;        // one-cycle pulse
   logic [DATA_WIDTH-1:0] rdata_regs;  // zero unless address is a control register
   logic [DATA_WIDTH-1:0] rdata_fifo;  // zero unless address is a fifo register

   modport master (
      output address, write_data, write, read,
      input  rdata_regs, rdata_fifo
   );

   modport regs (
      input  address, write_data, write,
      output rdata_regs
   );

   modport fifo (
      input  address, write_data, write, read,
      output rdata_fifo
   );

endinterface

// ==== pin_ctrl_if.sv ====
`timescale 1ns/1ps

interface pin_ctrl_if import husky_pkg::*; ();

   logic target_power;
   logic avrprog;
   logic debug_en;
   logic debug_swd;

   // static drive settings for the programming lines
   logic oe_nrst;
   logic val_nrst;
   logic oe_pdid;
   logic val_pdid;
   logic oe_pdic;
   logic val_pdic;

   logic [USERIO_WIDTH-1:0] userio_driven;
   logic [USERIO_WIDTH-1:0] userio_data;

   modport source (
      output target_power, avrprog, debug_en, debug_swd,
      output oe_nrst, val_nrst, oe_pdid, val_pdid, oe_pdic, val_pdic,
      output userio_driven, userio_data
   );

   modport sink (
      input  target_power, avrprog, debug_en, debug_swd,
      input  oe_nrst, val_nrst, oe_pdid, val_pdid, oe_pdic, val_pdic,
      input  userio_driven, userio_data
   );

endinterface

// ==== usb_reg_bridge.sv ====
`timescale 1ns/1ps

module usb_reg_bridge import husky_pkg::*; (
   input  logic                  clk_usb_buf,
   input  logic                  rst_n_i,
   input  logic [ADDR_WIDTH-1:0] usb_addr_i,
   input  logic [DATA_WIDTH-1:0] usb_data_i,
   input  logic                  usb_rdn_i,
   input  logic                  usb_wrn_i,
   input  logic                  usb_cen_i,
   input  logic                  usb_alen_i,
   output logic [DATA_WIDTH-1:0] usb_data_o,
   output logic                  usb_data_oe_o,
   reg_bus_if.master             bus
);

   logic                  wr_strobe;
   logic                  rd_strobe;
   logic                  rd_strobe_q;
   logic                  rd_start;
   logic                  write_q;
   logic                  read_q;
   logic [ADDR_WIDTH-1:0] addr_q;
   logic [DATA_WIDTH-1:0] wdata_q;
   logic [DATA_WIDTH-1:0] rdata_or_q;

   assign wr_strobe = ~usb_cen_i & ~usb_wrn_i;
   assign rd_strobe = ~usb_cen_i & ~usb_rdn_i;
   assign rd_start  = rd_strobe & ~rd_strobe_q;  // only the first low cycle counts

   assign usb_data_oe_o = rd_strobe;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         addr_q      <= '0;
         write_q     <= 1'b0;
         read_q      <= 1'b0;
         rd_strobe_q <= 1'b0;
      end else begin
         if (!usb_alen_i) begin
            addr_q <= usb_addr_i;  // transparent while alen is low
         end
         write_q     <= wr_strobe;
         read_q      <= rd_start;
         rd_strobe_q <= rd_strobe;
      end
   end

   // slaves return zero off their own addresses, so a plain OR is enough
   always_ff @(posedge clk_usb_buf) begin
      if (wr_strobe) begin
         wdata_q <= usb_data_i;
      end
      rdata_or_q <= bus.rdata_regs | bus.rdata_fifo;
      if (read_q) begin
         // fifo head bypasses the OR register, it moves on this very edge
         usb_data_o <= (addr_q == ADDR_FIFO_DATA) ? bus.rdata_fifo : rdata_or_q;
      end
   end

   assign bus.address    = addr_q;
   assign bus.write_data = wdata_q;
   assign bus.write      = write_q;
   assign bus.read       = read_q;

endmodule

// ==== cw_ctrl_regs.sv ====
`timescale 1ns/1ps

module cw_ctrl_regs import husky_pkg::*; (
   input  logic       clk_usb_buf,
   input  logic       rst_n_i,
   reg_bus_if.regs    bus,
   pin_ctrl_if.source pins
);

   logic [DATA_WIDTH-1:0]   target_ctrl_q;
   logic [DATA_WIDTH-1:0]   pin_oe_q;
   logic [DATA_WIDTH-1:0]   pin_val_q;
   logic [USERIO_WIDTH-1:0] userio_driven_q;
   logic [USERIO_WIDTH-1:0] userio_data_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         target_ctrl_q   <= '0;  // target power off
         pin_oe_q        <= '0;
         pin_val_q       <= '0;
         userio_driven_q <= '0;
         userio_data_q   <= '0;
      end else if (bus.write) begin
         case (bus.address)
            ADDR_TARGET_CTRL:   target_ctrl_q   <= bus.write_data;
            ADDR_PIN_OE:        pin_oe_q        <= bus.write_data;
            ADDR_PIN_VAL:       pin_val_q       <= bus.write_data;
            ADDR_USERIO_DRIVEN: userio_driven_q <= bus.write_data[USERIO_WIDTH-1:0];
            ADDR_USERIO_DATA:   userio_data_q   <= bus.write_data[USERIO_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // readback, all eight bits of each register
   always_comb begin
      case (bus.address)
         ADDR_TARGET_CTRL:   bus.rdata_regs = target_ctrl_q;
         ADDR_PIN_OE:        bus.rdata_regs = pin_oe_q;
         ADDR_PIN_VAL:       bus.rdata_regs = pin_val_q;
         ADDR_USERIO_DRIVEN: bus.rdata_regs = userio_driven_q;
         ADDR_USERIO_DATA:   bus.rdata_regs = userio_data_q;
         default:            bus.rdata_regs = '0;
      endcase
   end

   assign pins.target_power  = target_ctrl_q[TC_POWER];
   assign pins.avrprog       = target_ctrl_q[TC_AVRPROG];
   assign pins.debug_en      = target_ctrl_q[TC_DEBUG];
   assign pins.debug_swd     = target_ctrl_q[TC_DEBUG_SWD];

   assign pins.oe_nrst       = pin_oe_q[PIN_NRST];
   assign pins.val_nrst      = pin_val_q[PIN_NRST];
   assign pins.oe_pdid       = pin_oe_q[PIN_PDID];
   assign pins.val_pdid      = pin_val_q[PIN_PDID];
   assign pins.oe_pdic       = pin_oe_q[PIN_PDIC];
   assign pins.val_pdic      = pin_val_q[PIN_PDIC];

   assign pins.userio_driven = userio_driven_q;
   assign pins.userio_data   = userio_data_q;

endmodule

// ==== target_io_mux.sv ====
`timescale 1ns/1ps

module target_io_mux import husky_pkg::*; (
   pin_ctrl_if.sink                 pins,
   input  logic                     usb_spare0_i,
   input  logic                     sam_mosi_i,
   input  logic                     sam_spck_i,
   input  logic                     target_mosi_i,
   input  logic                     target_sck_i,
   input  logic                     target_pdid_i,
   input  logic                     target_pdic_i,
   input  logic                     target_miso_i,
   input  logic [USERIO_WIDTH-1:0]  userio_d_i,
   input  logic                     userio_clk_i,
   output logic                     target_nrst_o,
   output logic                     target_nrst_oe_o,
   output logic                     target_pdid_o,
   output logic                     target_pdid_oe_o,
   output logic                     target_pdic_o,
   output logic                     target_pdic_oe_o,
   output logic                     target_mosi_o,
   output logic                     target_mosi_oe_o,
   output logic                     target_sck_o,
   output logic                     target_sck_oe_o,
   output logic                     sam_miso_o,
   output logic                     sam_miso_oe_o,
   output logic [USERIO_WIDTH-1:0]  userio_d_o,
   output logic [USERIO_WIDTH-1:0]  userio_d_oe_o,
   output logic                     userio_clk_o,
   output logic                     userio_clk_oe_o
);

   logic swd_host;

   // swdio is passed from the header only while swclk is low
   assign swd_host = pins.debug_en & pins.debug_swd & ~userio_clk_i;

   assign target_pdid_o    = swd_host ? userio_d_i[6] : pins.val_pdid;
   assign target_pdid_oe_o = pins.target_power & (swd_host | pins.oe_pdid);

   assign target_pdic_o    = pins.val_pdic;
   assign target_pdic_oe_o = pins.target_power & pins.oe_pdic;

   assign target_nrst_o    = pins.avrprog ? usb_spare0_i : pins.val_nrst;  // sam drives reset
   assign target_nrst_oe_o = pins.target_power & (pins.avrprog | pins.oe_nrst);

   // spi lines only while programming
   assign target_mosi_o    = sam_mosi_i;
   assign target_mosi_oe_o = pins.target_power & pins.avrprog;
   assign target_sck_o     = sam_spck_i;
   assign target_sck_oe_o  = pins.target_power & pins.avrprog;

   assign sam_miso_o    = pins.debug_en ? userio_d_i[3] : target_miso_i;  // tdo in debug
   assign sam_miso_oe_o = pins.debug_en | pins.avrprog;

   // debug mode: tdi, tms/swdio and tck/swclk out on lines 7..5
   assign userio_d_o = pins.debug_en ?
                       {target_mosi_i, target_pdid_i, target_sck_i, {(USERIO_WIDTH-3){1'b0}}} :
                       pins.userio_data;
   assign userio_d_oe_o   = pins.userio_driven;

   assign userio_clk_o    = target_pdic_i;
   assign userio_clk_oe_o = pins.debug_en;

endmodule

// ==== capture_fifo.sv ====
`timescale 1ns/1ps

module capture_fifo import husky_pkg::*; (
   input  logic                  clk_usb_buf,
   input  logic                  rst_n_i,
   input  logic                  trace_capture_on_i,
   input  logic                  trace_wr_i,
   input  logic [DATA_WIDTH-1:0] trace_data_i,
   input  logic                  trace_flush_i,
   input  logic                  la_wr_i,
   input  logic [DATA_WIDTH-1:0] la_data_i,
   input  logic                  la_flush_i,
   reg_bus_if.fifo               bus,
   output logic                  error_o
);

   logic [DATA_WIDTH-1:0]     mem [FIFO_DEPTH];
   logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
   logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
   logic [FIFO_PTR_WIDTH-1:0] fill;
   logic [DATA_WIDTH-1:0]     wr_data;
   logic [DATA_WIDTH-1:0]     status;
   logic                      wr_en;
   logic                      push;
   logic                      pop;
   logic                      flush;
   logic                      clear_err;
   logic                      full_now;
   logic                      empty_now;
   logic                      empty_q;
   logic                      full_q;
   logic                      blocked_q;
   logic                      error_q;

   // trace owns the fifo while its capture is on, else the logic analyzer
   assign wr_en   = trace_capture_on_i ? trace_wr_i : la_wr_i;
   assign wr_data = trace_capture_on_i ? trace_data_i : la_data_i;
   assign flush   = trace_flush_i | la_flush_i;

   assign fill      = wr_ptr_q - rd_ptr_q;
   assign full_now  = (fill == FIFO_PTR_WIDTH'(FIFO_DEPTH));
   assign empty_now = (fill == '0);

   assign push      = wr_en & ~full_now & ~blocked_q;
   assign pop       = bus.read & (bus.address == ADDR_FIFO_DATA) & ~empty_now;
   assign clear_err = bus.write & (bus.address == ADDR_FIFO_STATUS) & bus.write_data[ST_ERROR];

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         empty_q   <= 1'b1;
         full_q    <= 1'b0;
         blocked_q <= 1'b0;
         error_q   <= 1'b0;
      end else begin
         if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
         end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (clear_err) begin
            blocked_q <= 1'b0;
            error_q   <= 1'b0;
         end else if (wr_en && !push) begin
            blocked_q <= 1'b1;  // a write was lost, hold off until cleared
            error_q   <= 1'b1;
         end
         empty_q <= empty_now;  // flags lag the pointers by one cycle
         full_q  <= full_now;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (push) begin
         mem[wr_ptr_q[FIFO_PTR_WIDTH-2:0]] <= wr_data;
      end
   end

   always_comb begin
      status             = '0;
      status[ST_EMPTY]   = empty_q;
      status[ST_FULL]    = full_q;
      status[ST_BLOCKED] = blocked_q;
      status[ST_ERROR]   = error_q;
      case (bus.address)
         ADDR_FIFO_STATUS: bus.rdata_fifo = status;
         ADDR_FIFO_DATA:   bus.rdata_fifo = mem[rd_ptr_q[FIFO_PTR_WIDTH-2:0]];  // head
         default:          bus.rdata_fifo = '0;
      endcase
   end

   assign error_o = error_q;

endmodule

// ==== status_leds.sv ====
`timescale 1ns/1ps

module status_leds import husky_pkg::*; (
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic fifo_error_i,
   input  logic monitor_error_i,
   input  logic pll_status_i,
   output logic led_adc_o,
   output logic led_fault_o
);

   logic [FLASH_BIT:0] flash_cnt_q;
   logic               flash;
   logic               any_error;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flash_cnt_q <= '0;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;  // free running
      end
   end

   assign flash     = flash_cnt_q[FLASH_BIT];
   assign any_error = fifo_error_i | monitor_error_i;

   // both leds flash together on any error
   assign led_adc_o   = any_error ? flash : ~pll_status_i;  // lit while pll unlocked
   assign led_fault_o = any_error & flash;

endmodule

// ==== husky_top.sv ====
`timescale 1ns/1ps

module husky_top import husky_pkg::*; (
   input  logic                    clk_usb_buf,
   input  logic                    rst_n_i,

   // parallel usb register bus
   input  logic [ADDR_WIDTH-1:0]   usb_addr_i,
   input  logic [DATA_WIDTH-1:0]   usb_data_i,
   input  logic                    usb_rdn_i,
   input  logic                    usb_wrn_i,
   input  logic                    usb_cen_i,
   input  logic                    usb_alen_i,
   output logic [DATA_WIDTH-1:0]   usb_data_o,
   output logic                    usb_data_oe_o,
   input  logic                    usb_spare0_i,

   // capture sources
   input  logic                    trace_capture_on_i,
   input  logic                    trace_wr_i,
   input  logic [DATA_WIDTH-1:0]   trace_data_i,
   input  logic                    trace_flush_i,
   input  logic                    la_wr_i,
   input  logic [DATA_WIDTH-1:0]   la_data_i,
   input  logic                    la_flush_i,

   // sam and target lines
   input  logic                    sam_mosi_i,
   input  logic                    sam_spck_i,
   output logic                    sam_miso_o,
   output logic                    sam_miso_oe_o,
   input  logic                    target_mosi_i,
   input  logic                    target_sck_i,
   input  logic                    target_pdid_i,
   input  logic                    target_pdic_i,
   input  logic                    target_miso_i,
   output logic                    target_nrst_o,
   output logic                    target_nrst_oe_o,
   output logic                    target_pdid_o,
   output logic                    target_pdid_oe_o,
   output logic                    target_pdic_o,
   output logic                    target_pdic_oe_o,
   output logic                    target_mosi_o,
   output logic                    target_mosi_oe_o,
   output logic                    target_sck_o,
   output logic                    target_sck_oe_o,

   // user-io header
   input  logic [USERIO_WIDTH-1:0] userio_d_i,
   input  logic                    userio_clk_i,
   output logic [USERIO_WIDTH-1:0] userio_d_o,
   output logic [USERIO_WIDTH-1:0] userio_d_oe_o,
   output logic                    userio_clk_o,
   output logic                    userio_clk_oe_o,

   input  logic                    monitor_error_i,
   input  logic                    pll_status_i,
   output logic                    led_adc_o,
   output logic                    led_fault_o
);

   logic fifo_error;

   reg_bus_if  bus ();
   pin_ctrl_if pins ();

   usb_reg_bridge u_usb_reg_bridge (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .bus           (bus)
   );

   cw_ctrl_regs u_cw_ctrl_regs (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .bus         (bus),
      .pins        (pins)
   );

   target_io_mux u_target_io_mux (
      .pins             (pins),
      .usb_spare0_i     (usb_spare0_i),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_mosi_i    (target_mosi_i),
      .target_sck_i     (target_sck_i),
      .target_pdid_i    (target_pdid_i),
      .target_pdic_i    (target_pdic_i),
      .target_miso_i    (target_miso_i),
      .userio_d_i       (userio_d_i),
      .userio_clk_i     (userio_clk_i),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_pdid_o    (target_pdid_o),
      .target_pdid_oe_o (target_pdid_oe_o),
      .target_pdic_o    (target_pdic_o),
      .target_pdic_oe_o (target_pdic_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o),
      .userio_d_o       (userio_d_o),
      .userio_d_oe_o    (userio_d_oe_o),
      .userio_clk_o     (userio_clk_o),
      .userio_clk_oe_o  (userio_clk_oe_o)
   );

   capture_fifo u_capture_fifo (
      .clk_usb_buf        (clk_usb_buf),
      .rst_n_i            (rst_n_i),
      .trace_capture_on_i (trace_capture_on_i),
      .trace_wr_i         (trace_wr_i),
      .trace_data_i       (trace_data_i),
      .trace_flush_i      (trace_flush_i),
      .la_wr_i            (la_wr_i),
      .la_data_i          (la_data_i),
      .la_flush_i         (la_flush_i),
      .bus                (bus),
      .error_o            (fifo_error)
   );

   status_leds u_status_leds (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .fifo_error_i    (fifo_error),
      .monitor_error_i (monitor_error_i),
      .pll_status_i    (pll_status_i),
      .led_adc_o       (led_adc_o),
      .led_fault_o     (led_fault_o)
   );

endmodule

// ==== tb_husky_top.sv ====
`timescale 1ns/1ps

module tb_husky_top import husky_pkg::*; ();

   localparam int CLK_PERIOD      = 8;
   localparam int WATCHDOG_CYCLES = 4000;  // all tests together need under 1000

   logic                    clk_usb_buf;
   logic                    rst_n_i;
   logic [ADDR_WIDTH-1:0]   usb_addr_i;
   logic [DATA_WIDTH-1:0]   usb_data_i;
   logic                    usb_rdn_i, usb_wrn_i, usb_cen_i, usb_alen_i;
   logic [DATA_WIDTH-1:0]   usb_data_o;
   logic                    usb_data_oe_o;
   logic                    usb_spare0_i;
   logic                    trace_capture_on_i, trace_wr_i, trace_flush_i;
   logic                    la_wr_i, la_flush_i;
   logic [DATA_WIDTH-1:0]   trace_data_i, la_data_i;
   logic                    sam_mosi_i, sam_spck_i, sam_miso_o, sam_miso_oe_o;
   logic                    target_mosi_i, target_sck_i, target_pdid_i;
   logic                    target_pdic_i, target_miso_i;
   logic                    target_nrst_o, target_nrst_oe_o, target_pdid_o, target_pdid_oe_o;
   logic                    target_pdic_o, target_pdic_oe_o, target_mosi_o, target_mosi_oe_o;
   logic                    target_sck_o, target_sck_oe_o;
   logic [USERIO_WIDTH-1:0] userio_d_i, userio_d_o, userio_d_oe_o;
   logic                    userio_clk_i, userio_clk_o, userio_clk_oe_o;
   logic                    monitor_error_i, pll_status_i, led_adc_o, led_fault_o;

   int          n_checks = 0;
   int          n_errors = 0;
   logic [31:0] rng_state = 32'd82;
   logic [7:0]  fifo_model[$];  // expected fifo contents, oldest first
   logic        model_blocked = 1'b0;

   husky_top dut (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_usb_buf);
      $display("watchdog expired after %0d clock periods, the run did not finish",
               WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   // output enable follows the read strobe every cycle
   assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
                    usb_data_oe_o == (!usb_cen_i && !usb_rdn_i))
      else begin
         $display("Mismatch at %0d ns: usb_data_oe_o expected %0b, got %0b", $time,
                  !$sampled(usb_cen_i) && !$sampled(usb_rdn_i), $sampled(usb_data_oe_o));
         n_errors++;
      end

   // fault led only lights during an error, where both leds flash together
   assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i) led_fault_o |-> led_adc_o)
      else begin
         $display("Mismatch at %0d ns: led_adc_o expected 1, got 0", $time);
         n_errors++;
      end

   function automatic logic [7:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state[7:0];
   endfunction

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
      n_checks++;
      assert (got === exp)
         else begin
            $display("Mismatch at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            n_errors++;
         end
   endtask

   task automatic check_true(input logic cond, input string what);
      n_checks++;
      assert (cond === 1'b1)
         else begin
            $display("at %0d ns: %s", $time, what);
            n_errors++;
         end
   endtask

   task automatic usb_write(input logic [7:0] addr, input logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_alen_i = 1'b0;
      usb_addr_i = addr;
      @(negedge clk_usb_buf);
      usb_alen_i = 1'b1;
      usb_data_i = data;
      usb_cen_i  = 1'b0;
      usb_wrn_i  = 1'b0;
      @(negedge clk_usb_buf);
      usb_cen_i  = 1'b1;
      usb_wrn_i  = 1'b1;
      @(negedge clk_usb_buf);  // register has taken the pulse
   endtask

   task automatic usb_read(input logic [7:0] addr, output logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_alen_i = 1'b0;
      usb_addr_i = addr;
      @(negedge clk_usb_buf);
      usb_alen_i = 1'b1;  // second address cycle feeds the OR register
      @(negedge clk_usb_buf);
      usb_cen_i = 1'b0;
      usb_rdn_i = 1'b0;
      repeat (2) @(negedge clk_usb_buf);
      data = usb_data_o;  // third rdn-low cycle
      check_true(usb_data_oe_o, "usb_data_oe_o was low during a read");
      @(negedge clk_usb_buf);
      usb_cen_i = 1'b1;
      usb_rdn_i = 1'b1;
   endtask

   task automatic capture_cycle(input logic t_wr, input logic [7:0] t_data,
                                input logic l_wr, input logic [7:0] l_data);
      @(negedge clk_usb_buf);
      trace_wr_i   = t_wr;
      trace_data_i = t_data;
      la_wr_i      = l_wr;
      la_data_i    = l_data;
      @(negedge clk_usb_buf);
      trace_wr_i = 1'b0;
      la_wr_i    = 1'b0;
   endtask

   // full or blocked fifo drops the byte and blocks
   function automatic void model_push(input logic [7:0] data);
      if (!model_blocked && fifo_model.size() < FIFO_DEPTH) fifo_model.push_back(data);
      else model_blocked = 1'b1;
   endfunction

   task automatic check_status();
      logic [7:0] exp;
      logic [7:0] got;
      exp             = '0;
      exp[ST_EMPTY]   = (fifo_model.size() == 0);
      exp[ST_FULL]    = (fifo_model.size() == FIFO_DEPTH);
      exp[ST_BLOCKED] = model_blocked;
      exp[ST_ERROR]   = model_blocked;
      usb_read(ADDR_FIFO_STATUS, got);
      check_eq("fifo status", exp, got);
   endtask

   task automatic drain_fifo();
      logic [7:0] got;
      while (fifo_model.size() > 0) begin
         usb_read(ADDR_FIFO_DATA, got);
         check_eq("usb_data_o", fifo_model.pop_front(), got);
      end
   endtask

   // started on a rising flash edge, both leds are high for 32 clocks of each 64
   task automatic check_flash();
      for (int i = 0; i < 64; i++) begin
         @(negedge clk_usb_buf);
         check_eq("led_fault_o", (i < 32), led_fault_o);
         check_eq("led_adc_o", (i < 32), led_adc_o);
      end
   endtask

   task automatic end_test(input string name, input int errors_before);
      $display("test %-16s %s", name, (n_errors == errors_before) ? "ok" : "had errors");
   endtask

   initial begin
      int          err_start;
      logic [7:0]  rd;
      logic [7:0]  vals[5];
      logic [7:0]  addrs[5];
      logic [7:0]  d;
      time         t0;
      time         t1;
      time         t2;

      rst_n_i = 1'b0;
      usb_addr_i = '0;
      usb_data_i = '0;
      usb_rdn_i = 1'b1;
      usb_wrn_i = 1'b1;
      usb_cen_i = 1'b1;
      usb_alen_i = 1'b1;
      usb_spare0_i = 1'b0;
      trace_capture_on_i = 1'b0;
      trace_wr_i = 1'b0;
      trace_data_i = '0;
      trace_flush_i = 1'b0;
      la_wr_i = 1'b0;
      la_data_i = '0;
      la_flush_i = 1'b0;
      sam_mosi_i = 1'b0;
      sam_spck_i = 1'b0;
      target_mosi_i = 1'b0;
      target_sck_i = 1'b0;
      target_pdid_i = 1'b0;
      target_pdic_i = 1'b0;
      target_miso_i = 1'b0;
      userio_d_i = '0;
      userio_clk_i = 1'b0;
      monitor_error_i = 1'b0;
      pll_status_i = 1'b1;
      repeat (8) @(negedge clk_usb_buf);
      rst_n_i = 1'b1;

      // reset state
      err_start = n_errors;
      @(negedge clk_usb_buf);
      check_eq("usb_data_oe_o", 0, usb_data_oe_o);
      check_eq("target oe", 0, {target_nrst_oe_o, target_pdid_oe_o, target_pdic_oe_o,
                                target_mosi_oe_o, target_sck_oe_o, sam_miso_oe_o});
      check_eq("userio_d_oe_o", 0, userio_d_oe_o);
      check_eq("userio_clk_oe_o", 0, userio_clk_oe_o);
      check_eq("led_fault_o", 0, led_fault_o);
      check_status();
      end_test("reset", err_start);

      // register readback
      err_start = n_errors;
      addrs = '{ADDR_TARGET_CTRL, ADDR_PIN_OE, ADDR_PIN_VAL, ADDR_USERIO_DRIVEN,
                ADDR_USERIO_DATA};
      foreach (addrs[i]) begin
         vals[i] = next_rand();
         usb_write(addrs[i], vals[i]);
      end
      foreach (addrs[i]) begin
         usb_read(addrs[i], rd);
         check_eq($sformatf("readback 0x%0h", addrs[i]), vals[i], rd);
      end
      usb_read(8'h05, rd);
      check_eq("unmapped readback", 0, rd);
      end_test("registers", err_start);

      // pin rules, values nrst 1, pdid 0, pdic 1
      err_start = n_errors;
      usb_write(ADDR_PIN_OE, 8'h07);
      usb_write(ADDR_PIN_VAL, 8'h05);
      usb_write(ADDR_TARGET_CTRL, 8'h00);
      check_eq("target oe, power off", 0, {target_nrst_oe_o, target_pdid_oe_o,
                                           target_pdic_oe_o, target_mosi_oe_o, target_sck_oe_o});
      usb_write(ADDR_TARGET_CTRL, 8'h01 << TC_POWER);
      check_eq("target oe, power on", 5'b11100, {target_nrst_oe_o, target_pdid_oe_o,
                                                target_pdic_oe_o, target_mosi_oe_o,
                                                target_sck_oe_o});
      check_eq("target values", 3'b101, {target_nrst_o, target_pdid_o, target_pdic_o});
      usb_write(ADDR_TARGET_CTRL, (8'h01 << TC_POWER) | (8'h01 << TC_AVRPROG));
      repeat (4) begin
         d = next_rand();
         {usb_spare0_i, sam_mosi_i, sam_spck_i, target_miso_i} = d[3:0];
         @(negedge clk_usb_buf);
         check_eq("target_nrst_o", d[3], target_nrst_o);
         check_eq("target_mosi_o", d[2], target_mosi_o);
         check_eq("target_sck_o", d[1], target_sck_o);
         check_eq("sam_miso_o", d[0], sam_miso_o);
         check_eq("programming oe", 4'hf, {target_nrst_oe_o, target_mosi_oe_o,
                                            target_sck_oe_o, sam_miso_oe_o});
      end
      usb_write(ADDR_TARGET_CTRL, (8'h01 << TC_POWER) | (8'h01 << TC_DEBUG) |
                                  (8'h01 << TC_DEBUG_SWD));
      repeat (4) begin
         userio_d_i = next_rand();
         d = next_rand();
         {target_mosi_i, target_pdid_i, target_sck_i, target_pdic_i} = d[3:0];
         userio_clk_i = 1'b0;
         @(negedge clk_usb_buf);
         check_eq("target_pdid_o", userio_d_i[6], target_pdid_o);
         check_eq("target_pdid_oe_o", 1, target_pdid_oe_o);
         check_eq("sam_miso_o", userio_d_i[3], sam_miso_o);
         check_eq("sam_miso_oe_o", 1, sam_miso_oe_o);
         check_eq("userio_d_o", {d[3:1], 5'b00000}, userio_d_o);
         check_eq("userio_clk_o", d[0], userio_clk_o);
         check_eq("userio_clk_oe_o", 1, userio_clk_oe_o);
         userio_clk_i = 1'b1;  // swclk high hands pdid back to its register value
         @(negedge clk_usb_buf);
         check_eq("target_pdid_o", 0, target_pdid_o);
      end
      usb_write(ADDR_TARGET_CTRL, 8'h01 << TC_POWER);
      vals[0] = next_rand();
      vals[1] = next_rand();
      usb_write(ADDR_USERIO_DRIVEN, vals[0]);
      usb_write(ADDR_USERIO_DATA, vals[1]);
      check_eq("userio_d_oe_o", vals[0], userio_d_oe_o);
      check_eq("userio_d_o", vals[1], userio_d_o);
      check_eq("userio_clk_oe_o", 0, userio_clk_oe_o);
      end_test("pins", err_start);

      // fifo sources, order and flush
      err_start = n_errors;
      trace_capture_on_i = 1'b1;
      repeat (6) begin
         d = next_rand();
         capture_cycle(1'b1, d, 1'b1, next_rand());
         model_push(d);
      end
      trace_capture_on_i = 1'b0;
      repeat (5) begin
         d = next_rand();
         capture_cycle(1'b1, next_rand(), 1'b1, d);
         model_push(d);
      end
      check_status();
      drain_fifo();
      check_status();
      for (int src = 0; src < 2; src++) begin
         trace_capture_on_i = (src == 0);
         repeat (3) begin
            d = next_rand();
            capture_cycle(src == 0, d, src == 1, d);
            model_push(d);
         end
         @(negedge clk_usb_buf);
         trace_flush_i = (src == 0);
         la_flush_i    = (src == 1);
         @(negedge clk_usb_buf);
         trace_flush_i = 1'b0;
         la_flush_i    = 1'b0;
         fifo_model.delete();
         check_status();
      end
      end_test("fifo", err_start);

      // overflow, blocking and the flashing leds
      err_start = n_errors;
      trace_capture_on_i = 1'b0;
      repeat (FIFO_DEPTH + 1) begin
         d = next_rand();
         capture_cycle(1'b0, 8'h00, 1'b1, d);
         model_push(d);
      end
      check_status();
      drain_fifo();
      capture_cycle(1'b0, 8'h00, 1'b1, next_rand());  // dropped while blocked
      model_push(8'h00);
      check_status();
      @(posedge led_fault_o);
      t0 = $time;
      @(negedge led_fault_o);
      t1 = $time;
      @(posedge led_fault_o);
      t2 = $time;
      check_eq("led_fault_o high time", 32 * CLK_PERIOD, t1 - t0);
      check_eq("led_fault_o period", 64 * CLK_PERIOD, t2 - t0);
      check_flash();
      usb_write(ADDR_FIFO_STATUS, 8'h01 << ST_ERROR);
      model_blocked = 1'b0;
      check_status();
      for (int i = 0; i < 70; i++) begin
         pll_status_i = i[3];
         @(negedge clk_usb_buf);
         check_eq("led_fault_o", 0, led_fault_o);
         check_eq("led_adc_o", !pll_status_i, led_adc_o);
      end
      monitor_error_i = 1'b1;  // monitor error overrides the pll led the same way
      @(negedge led_fault_o);
      @(posedge led_fault_o);
      check_flash();
      monitor_error_i = 1'b0;
      @(negedge clk_usb_buf);
      check_eq("led_fault_o", 0, led_fault_o);
      check_eq("led_adc_o", !pll_status_i, led_adc_o);
      end_test("overflow", err_start);

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
husky_pkg.sv
reg_bus_if.sv
pin_ctrl_if.sv
usb_reg_bridge.sv
cw_ctrl_regs.sv
target_io_mux.sv
capture_fifo.sv
status_leds.sv
husky_top.sv
tb_husky_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_husky_top
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
